// ==== logic/frv_core_pkg.sv ====
/*
 * Core constants for the RV32I front end.
 * Holds the datapath width, the reset fetch address and the struct
 * that carries one fetched word from fetch to decode.
 */
package frv_core_pkg;

    // ---------------------------------------------------------------------
    // Core constants
    // ---------------------------------------------------------------------

    localparam int unsigned XLEN = 32; // Data and address width

    localparam logic [XLEN-1:0] PC_RESET_VALUE = 32'h8000_0000; // First fetch address

    // ---------------------------------------------------------------------
    // Fetch to decode
    // ---------------------------------------------------------------------

    typedef struct packed {
        logic [XLEN-1:0] data;  // Raw instruction word
        logic [XLEN-1:0] pc;    // Address it was read from
        logic            error; // Memory flagged the read
    } frv_fetch_t;

endpackage : frv_core_pkg

// ==== logic/frv_decode_pkg.sv ====
/*
 * Decode encodings for the RV32I front end.
 * Major opcodes, micro-ops, functional units and the decoded
 * instruction that the stage register hands to dispatch.
 */
package frv_decode_pkg;

    // ---------------------------------------------------------------------
    // Base ISA major opcodes, all with low bits 2'b11
    // ---------------------------------------------------------------------

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } frv_opcode_e;

    // ---------------------------------------------------------------------
    // Pipeline encodings
    // ---------------------------------------------------------------------

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR,          // ALU arithmetic and logic
        SLL, SRL, SRA, SLT, SLTU,        // Shifts and compares
        LUI, AUIPC,                      // Upper immediates
        LOAD, STORE,                     // Memory access
        BEQ, BNE, BLT, BGE, BLTU, BGEU,  // Conditional branches
        JAL, JALR,                       // Jumps
        ILLEGAL, IFETCH_ERR              // Trap causes
    } frv_uop_e;

    typedef enum logic [2:0] {
        ALU, MEM, JUMP, BRANCH, NONE
    } frv_fu_e;

    typedef struct packed {
        logic use_rs1; // Operand A from rs1
        logic use_rs2; // Operand B from rs2
        logic use_imm; // Operand B from immediate
        logic use_pc;  // Operand A from pc
    } frv_opr_src_t;

    typedef struct packed {
        logic [4:0]                    rd;
        logic [4:0]                    rs1;
        logic [4:0]                    rs2;
        logic [frv_core_pkg::XLEN-1:0] imm;     // Sign extended immediate
        logic [frv_core_pkg::XLEN-1:0] pc;
        frv_uop_e                      uop;
        frv_fu_e                       fu;
        logic                          trap;    // Raise a trap at dispatch
        frv_opr_src_t                  opr_src;
        logic [31:0]                   instr;   // Original word
    } frv_decoded_t;

endpackage : frv_decode_pkg

// ==== logic/frv_pipeline_fetch.sv ====
/*
 * Instruction fetch stage.
 * Issues instruction memory reads, steps the fetch address and takes
 * control flow redirects, then packs each returned word for decode.
 */
module frv_pipeline_fetch (
    input  logic                          g_clk,
    input  logic                          g_resetn,
    input  logic                          i_cf_req,     // Redirect request
    input  logic [frv_core_pkg::XLEN-1:0] i_cf_target,  // Redirect address
    output logic                          o_cf_ack,     // Redirect taken
    output logic                          o_imem_cen,   // Read enable
    output logic [frv_core_pkg::XLEN-1:0] o_imem_addr,  // Read address
    input  logic                          i_imem_stall, // Memory not ready
    input  logic                          i_imem_error, // Bus error on read
    input  logic [frv_core_pkg::XLEN-1:0] i_imem_rdata, // Read data
    input  logic                          i_fe_stall,   // Downstream full
    output logic                          o_fe_ready,   // Word valid for decode
    output frv_core_pkg::frv_fetch_t      o_fetch       // Word, pc and error
);

    import frv_core_pkg::*;

    logic [XLEN-1:0] fetch_addr_q; // Address of the next read
    logic            read_accept;  // Memory took the read this cycle

    // ---------------------------------------------------------------------
    // Memory request
    // ---------------------------------------------------------------------

    assign o_cf_ack    = i_cf_req;                 // Redirects complete at once
    assign o_imem_cen  = !i_fe_stall && !i_cf_req; // No read into a full stage
    assign o_imem_addr = fetch_addr_q;
    assign read_accept = o_imem_cen && !i_imem_stall;

    // cen is already low on a redirect, so a returned word is never stale
    assign o_fe_ready = read_accept;

    // ---------------------------------------------------------------------
    // Returned word
    // ---------------------------------------------------------------------

    assign o_fetch.data  = i_imem_rdata;
    assign o_fetch.pc    = fetch_addr_q; // pc travels with the word
    assign o_fetch.error = i_imem_error;

    // ---------------------------------------------------------------------
    // Fetch address
    // ---------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            fetch_addr_q <= PC_RESET_VALUE;
        end else if (i_cf_req) begin
            fetch_addr_q <= i_cf_target;              // Redirect wins
        end else if (read_accept) begin
            fetch_addr_q <= fetch_addr_q + XLEN'(4);  // Next sequential word
        end
    end

endmodule : frv_pipeline_fetch

// ==== logic/frv_pipeline_decode.sv ====
/*
 * Instruction decoder.
 * Turns an RV32I word into micro-op, functional unit, operand sources
 * and immediate. Purely combinational.
 */
module frv_pipeline_decode (
    input  frv_core_pkg::frv_fetch_t     i_fetch,  // Word from fetch
    output frv_decode_pkg::frv_decoded_t o_decoded // Wide pipeline encoding
);

    import frv_core_pkg::*;
    import frv_decode_pkg::*;

    logic [31:0]     word;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    frv_uop_e        uop;
    frv_fu_e         fu;
    frv_opr_src_t    src;
    logic [XLEN-1:0] imm;

    // ALU ops shared by OP and OP-IMM, funct7 only matters for shifts on OP-IMM
    function automatic frv_uop_e alu_uop(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic is_imm);
        logic     f7_ok;
        frv_uop_e u;
        f7_ok = is_imm || (f7 == 7'h00);
        u     = ILLEGAL;
        case (f3)
            3'b000: begin
                if (f7_ok) u = ADD;
                else if (f7 == 7'h20) u = SUB;
            end
            3'b001: if (f7 == 7'h00) u = SLL;
            3'b010: if (f7_ok) u = SLT;
            3'b011: if (f7_ok) u = SLTU;
            3'b100: if (f7_ok) u = XOR;
            3'b101: begin
                if (f7 == 7'h00) u = SRL;
                else if (f7 == 7'h20) u = SRA;
            end
            3'b110: if (f7_ok) u = OR;
            default: if (f7_ok) u = AND;
        endcase
        return u;
    endfunction

    // ---------------------------------------------------------------------
    // Fields and immediates
    // ---------------------------------------------------------------------

    assign word   = i_fetch.data;
    assign opcode = word[6:0];   // Low bits other than 2'b11 match no opcode
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];

    assign imm_i = {{20{word[31]}}, word[31:20]};
    assign imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    // ---------------------------------------------------------------------
    // Opcode decode
    // ---------------------------------------------------------------------

    always_comb begin
        uop = ILLEGAL;
        fu  = NONE;
        src = '0;
        imm = '0;
        case (opcode)
            OPC_LUI: begin
                uop = LUI;
                fu  = ALU;
                imm = imm_u;
                src.use_imm = 1'b1;
            end
            OPC_AUIPC: begin
                uop = AUIPC;
                fu  = ALU;
                imm = imm_u;
                src = '{use_rs1: 1'b0, use_rs2: 1'b0, use_imm: 1'b1, use_pc: 1'b1};
            end
            OPC_JAL: begin
                uop = JAL;
                fu  = JUMP;
                imm = imm_j;
                src = '{use_rs1: 1'b0, use_rs2: 1'b0, use_imm: 1'b1, use_pc: 1'b1};
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) uop = JALR;
                fu  = JUMP;
                imm = imm_i;
                src = '{use_rs1: 1'b1, use_rs2: 1'b0, use_imm: 1'b1, use_pc: 1'b0};
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  uop = BEQ;
                    3'b001:  uop = BNE;
                    3'b100:  uop = BLT;
                    3'b101:  uop = BGE;
                    3'b110:  uop = BLTU;
                    3'b111:  uop = BGEU;
                    default: uop = ILLEGAL; // 010 and 011 unused
                endcase
                fu  = BRANCH;
                imm = imm_b;
                src = '{use_rs1: 1'b1, use_rs2: 1'b1, use_imm: 1'b1, use_pc: 1'b1};
            end
            OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) uop = LOAD;
                fu  = MEM;
                imm = imm_i;
                src = '{use_rs1: 1'b1, use_rs2: 1'b0, use_imm: 1'b1, use_pc: 1'b0};
            end
            OPC_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) uop = STORE;
                fu  = MEM;
                imm = imm_s;
                src = '{use_rs1: 1'b1, use_rs2: 1'b1, use_imm: 1'b1, use_pc: 1'b0};
            end
            OPC_OP_IMM: begin
                uop = alu_uop(funct3, funct7, 1'b1);
                fu  = ALU;
                // Shift amount only, funct7 is not part of the operand
                imm = (funct3[1:0] == 2'b01) ? {27'b0, word[24:20]} : imm_i;
                src = '{use_rs1: 1'b1, use_rs2: 1'b0, use_imm: 1'b1, use_pc: 1'b0};
            end
            OPC_OP: begin
                uop = alu_uop(funct3, funct7, 1'b0);
                fu  = ALU;
                src = '{use_rs1: 1'b1, use_rs2: 1'b1, use_imm: 1'b0, use_pc: 1'b0};
            end
            default: uop = ILLEGAL;
        endcase

        if (i_fetch.error) uop = IFETCH_ERR; // Bus error beats any encoding
        if (uop inside {ILLEGAL, IFETCH_ERR}) begin
            fu  = NONE;
            src = '0;
            imm = '0;
        end
    end

    // ---------------------------------------------------------------------
    // Output packing
    // ---------------------------------------------------------------------

    assign o_decoded.rd      = word[11:7];
    assign o_decoded.rs1     = word[19:15];
    assign o_decoded.rs2     = word[24:20];
    assign o_decoded.imm     = imm;
    assign o_decoded.pc      = i_fetch.pc;
    assign o_decoded.uop     = uop;
    assign o_decoded.fu      = fu;
    assign o_decoded.trap    = (uop == ILLEGAL) || (uop == IFETCH_ERR);
    assign o_decoded.opr_src = src;
    assign o_decoded.instr   = word;

endmodule : frv_pipeline_decode

// ==== logic/frv_pipeline_register.sv ====
/*
 * Front end output stage register.
 * Holds one decoded instruction under a valid/busy handshake and
 * drops it on a pipeline flush.
 */
module frv_pipeline_register (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    input  logic                         i_valid, // New item from decode
    input  frv_decode_pkg::frv_decoded_t i_data,
    input  logic                         i_flush, // Control flow change
    output logic                         o_busy,  // Full and not draining
    output logic                         o_valid, // Item held for dispatch
    output frv_decode_pkg::frv_decoded_t o_data,
    input  logic                         i_busy   // Dispatch cannot take it
);

    import frv_decode_pkg::*;

    logic         valid_q;
    frv_decoded_t data_q;  // Payload, qualified by valid_q
    logic         load;

    assign o_busy = valid_q && i_busy; // Stuck item blocks new fetches
    assign load   = i_valid && !o_busy;

    // Valid tracking
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;    // Wrong path item
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (!i_busy) begin
            valid_q <= 1'b0;    // Left this cycle, nothing new
        end
    end

    always_ff @(posedge g_clk) begin
        if (load) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule : frv_pipeline_register

// ==== logic/frv_pipeline_front.sv ====
/*
 * Pipeline front end.
 * Fetch, decode and the output stage register, handing decoded RV32I
 * instructions to dispatch and taking control flow redirects.
 */
module frv_pipeline_front (
    input  logic                          g_clk,
    input  logic                          g_resetn,
    input  logic                          i_cf_req,     // Control flow change
    input  logic [frv_core_pkg::XLEN-1:0] i_cf_target,  // Change destination
    output logic                          o_cf_ack,     // Change accepted
    output logic                          o_imem_cen,   // Chip enable
    output logic [frv_core_pkg::XLEN-1:0] o_imem_addr,  // Read address
    input  logic                          i_imem_stall, // Memory stall
    input  logic                          i_imem_error, // Read error
    input  logic [frv_core_pkg::XLEN-1:0] i_imem_rdata, // Read data
    output logic                          o_s2_valid,   // Item for dispatch
    input  logic                          i_s2_busy,    // Dispatch stalled
    output frv_decode_pkg::frv_decoded_t  o_s2          // Decoded instruction
);

    import frv_core_pkg::*;
    import frv_decode_pkg::*;

    frv_fetch_t   fetch;     // Fetched word with pc and error
    frv_decoded_t decoded;   // Decoder output into the stage register
    logic         fe_ready;  // Fetched word valid this cycle
    logic         s1_busy;   // Stage register full and stuck

    // ---------------------------------------------------------------------
    // Fetch
    // ---------------------------------------------------------------------

    frv_pipeline_fetch i_frv_pipeline_fetch (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .i_cf_req     (i_cf_req),
        .i_cf_target  (i_cf_target),
        .o_cf_ack     (o_cf_ack),
        .o_imem_cen   (o_imem_cen),
        .o_imem_addr  (o_imem_addr),
        .i_imem_stall (i_imem_stall),
        .i_imem_error (i_imem_error),
        .i_imem_rdata (i_imem_rdata),
        .i_fe_stall   (s1_busy),
        .o_fe_ready   (fe_ready),
        .o_fetch      (fetch)
    );

    // ---------------------------------------------------------------------
    // Decode and stage register
    // ---------------------------------------------------------------------

    frv_pipeline_decode i_frv_pipeline_decode (
        .i_fetch   (fetch),
        .o_decoded (decoded)
    );

    // ack always equals req, so every request is the flush event
    frv_pipeline_register i_frv_pipeline_register (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (fe_ready),
        .i_data   (decoded),
        .i_flush  (i_cf_req),
        .o_busy   (s1_busy),
        .o_valid  (o_s2_valid),
        .o_data   (o_s2),
        .i_busy   (i_s2_busy)
    );

endmodule : frv_pipeline_front

// ==== sim/frv_front_model.svh ====
/*
 * Reference model for the front end testbench.
 * Instruction table served by the memory model and the expected
 * decode of a word under the RV32I base encoding rules.
 */

// Memory contents, one word per address bits 5 to 2
function automatic logic [31:0] rom_word(input logic [3:0] idx);
    case (idx)
        4'h0:    return 32'h0050_0093; // addi x1, x0, 5
        4'h1:    return 32'h4020_8133; // sub x2, x1, x2
        4'h2:    return 32'hfff0_c193; // xori x3, x1, -1
        4'h3:    return 32'h4030_d213; // srai x4, x1, 3
        4'h4:    return 32'h1234_52b7; // lui x5, 0x12345
        4'h5:    return 32'hffff_f317; // auipc x6, 0xfffff
        4'h6:    return 32'hffc1_2383; // lw x7, -4(x2)
        4'h7:    return 32'h0071_2423; // sw x7, 8(x2)
        4'h8:    return 32'hfe20_8ee3; // beq x1, x2, -4
        4'h9:    return 32'h0020_f463; // bgeu x1, x2, 8
        4'ha:    return 32'h0080_00ef; // jal x1, 8
        4'hb:    return 32'h0000_80e7; // jalr x1, 0(x1)
        4'hc:    return 32'h0020_b533; // sltu x10, x1, x2
        4'hd:    return 32'h0020_9593; // slli x11, x1, 2
        4'he:    return 32'hffff_ffff; // No such opcode
        default: return 32'h0000_4501; // 16-bit encoding
    endcase
endfunction

// ALU micro-op from {funct7, funct3}
function automatic frv_uop_e alu_op(input logic [9:0] key);
    case (key)
        10'h000: return ADD;
        10'h100: return SUB;
        10'h001: return SLL;
        10'h002: return SLT;
        10'h003: return SLTU;
        10'h004: return XOR;
        10'h005: return SRL;
        10'h105: return SRA;
        10'h006: return OR;
        10'h007: return AND;
        default: return ILLEGAL;
    endcase
endfunction

function automatic frv_uop_e branch_op(input logic [2:0] f3);
    case (f3)
        3'd0:    return BEQ;
        3'd1:    return BNE;
        3'd4:    return BLT;
        3'd5:    return BGE;
        3'd6:    return BLTU;
        3'd7:    return BGEU;
        default: return ILLEGAL;
    endcase
endfunction

// Operand flags below are {rs1, rs2, imm, pc}
function automatic frv_decoded_t expected_decode(input logic [31:0] w,
                                                 input logic [31:0] pc, input logic err);
    frv_decoded_t d;
    logic [2:0]   f3;
    logic [9:0]   imm_key;
    logic [31:0]  imm_i;
    logic [31:0]  imm_s;
    logic [31:0]  imm_b;
    logic [31:0]  imm_j;
    d       = '0;
    f3      = w[14:12];
    imm_key = (f3[1:0] == 2'b01) ? {w[31:25], f3} : {7'h00, f3}; // funct7 only for shifts
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    d.rd    = w[11:7];
    d.rs1   = w[19:15];
    d.rs2   = w[24:20];
    d.pc    = pc;
    d.instr = w;
    d.uop   = ILLEGAL;
    case (w[6:0])
        7'h37: {d.uop, d.fu, d.opr_src, d.imm} = {LUI, ALU, 4'b0010, w[31:12], 12'h000};
        7'h17: {d.uop, d.fu, d.opr_src, d.imm} = {AUIPC, ALU, 4'b0011, w[31:12], 12'h000};
        7'h6f: {d.uop, d.fu, d.opr_src, d.imm} = {JAL, JUMP, 4'b0011, imm_j};
        7'h67: {d.uop, d.fu, d.opr_src, d.imm} =
                   {(f3 == 3'd0) ? JALR : ILLEGAL, JUMP, 4'b1010, imm_i};
        7'h63: {d.uop, d.fu, d.opr_src, d.imm} = {branch_op(f3), BRANCH, 4'b1111, imm_b};
        7'h03: {d.uop, d.fu, d.opr_src, d.imm} =
                   {(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? LOAD : ILLEGAL,
                    MEM, 4'b1010, imm_i};
        7'h23: {d.uop, d.fu, d.opr_src, d.imm} =
                   {(f3 <= 3'd2) ? STORE : ILLEGAL, MEM, 4'b1110, imm_s};
        7'h13: {d.uop, d.fu, d.opr_src, d.imm} = {alu_op(imm_key), ALU, 4'b1010,
                   (f3[1:0] == 2'b01) ? {27'd0, w[24:20]} : imm_i};
        7'h33: {d.uop, d.fu, d.opr_src, d.imm} =
                   {alu_op({w[31:25], f3}), ALU, 4'b1100, 32'h0};
        default: d.uop = ILLEGAL; // Includes every 16-bit encoding
    endcase
    if (err)
        d.uop = IFETCH_ERR;          // Bus error overrides the word
    if (d.uop == ILLEGAL || d.uop == IFETCH_ERR) begin
        {d.fu, d.opr_src, d.imm} = {NONE, 4'b0000, 32'h0};
        d.trap = 1'b1;
    end
    return d;
endfunction

// ==== sim/frv_front_tb.sv ====
/*
 * Testbench for the pipeline front end.
 * Random memory stalls, bus errors, dispatch back-pressure and redirects,
 * with every item leaving the stage register checked against a model.
 */
module frv_front_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import frv_core_pkg::*;
    import frv_decode_pkg::*;

    `include "frv_front_model.svh"

    logic         g_clk = 1'b0;
    logic         g_resetn;
    logic         cf_req;
    logic [31:0]  cf_target;
    logic         cf_ack;
    logic         imem_cen;
    logic [31:0]  imem_addr;
    logic         imem_stall;
    logic         imem_error;
    logic [31:0]  imem_rdata;
    logic         s2_valid;
    logic         s2_busy;
    frv_decoded_t s2;

    integer       seed = 96565;
    int           errors = 0;
    int           transfers = 0;
    int           redirects = 0;
    int           n_illegal = 0;
    int           n_fetch_err = 0;

    logic         slot_full;    // One read accepted, not yet at dispatch
    logic [31:0]  slot_pc;
    logic         slot_err;
    logic [31:0]  exp_pc;       // pc the next item must carry
    logic         hold_pending; // Item stuck last cycle
    frv_decoded_t hold_item;

    frv_pipeline_front i_frv_pipeline_front (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .i_cf_req     (cf_req),
        .i_cf_target  (cf_target),
        .o_cf_ack     (cf_ack),
        .o_imem_cen   (imem_cen),
        .o_imem_addr  (imem_addr),
        .i_imem_stall (imem_stall),
        .i_imem_error (imem_error),
        .i_imem_rdata (imem_rdata),
        .o_s2_valid   (s2_valid),
        .i_s2_busy    (s2_busy),
        .o_s2         (s2)
    );

    always #4 g_clk = ~g_clk; // 8 ns period

    // Memory answers from the address held since the last rising edge
    task automatic drive_inputs();
        logic [31:0] rnd;
        rnd        = $random(seed);
        imem_rdata = rom_word(imem_addr[5:2]);
        imem_stall = (rnd[1:0] == 2'b00);
        imem_error = (rnd[4:2] == 3'b000);       // 1 in 8
        s2_busy    = (rnd[6:5] == 2'b00);
        cf_req     = (rnd[11:8] == 4'h0);
        cf_target  = {PC_RESET_VALUE[31:6], rnd[15:12], 2'b00};
    endtask

    // ---------------------------------------------------------------------
    // Checker, mid low phase when all inputs are settled
    // ---------------------------------------------------------------------

    always begin : compare
        logic         accept;
        logic         xfer;
        frv_decoded_t want;
        @(negedge g_clk);
        #2;
        if (g_resetn) begin
            accept = imem_cen && !imem_stall;
            xfer   = s2_valid && !s2_busy;
            if (hold_pending) begin
                assert (s2_valid && s2 == hold_item) else begin
                    errors++;
                    $display("CHECK FAILED o_s2 under busy got %h expected %h", s2, hold_item);
                end
            end
            if (s2_valid && s2_busy) begin
                assert (!imem_cen) else begin
                    errors++;
                    $display("CHECK FAILED o_imem_cen got %h expected 0", imem_cen);
                end
            end
            if (cf_req) begin
                assert (cf_ack) else begin
                    errors++;
                    $display("CHECK FAILED o_cf_ack got %h expected 1", cf_ack);
                end
            end
            if (xfer) begin
                want = expected_decode(rom_word(slot_pc[5:2]), slot_pc, slot_err);
                assert (slot_full) else begin
                    errors++;
                    $display("An item reached dispatch with no accepted read behind it");
                end
                assert (s2.pc == exp_pc) else begin
                    errors++;
                    $display("CHECK FAILED o_s2.pc got %h expected %h", s2.pc, exp_pc);
                end
                assert (s2 == want) else begin
                    errors++;
                    $display("CHECK FAILED o_s2 got %h expected %h", s2, want);
                end
                slot_full = 1'b0;
                exp_pc    = exp_pc + 32'd4;
                transfers++;
                n_illegal   += (want.uop == ILLEGAL) ? 1 : 0;
                n_fetch_err += (want.uop == IFETCH_ERR) ? 1 : 0;
            end
            hold_pending = s2_valid && s2_busy && !cf_req;
            hold_item    = s2;
            if (cf_req) begin
                slot_full = 1'b0;       // Held item and fetch stream dropped
                exp_pc    = cf_target;
                redirects++;
            end
            if (accept) begin
                assert (!slot_full) else begin
                    errors++;
                    $display("A read was accepted while an earlier item was still pending");
                end
                assert (imem_addr == exp_pc) else begin
                    errors++;
                    $display("CHECK FAILED o_imem_addr got %h expected %h", imem_addr, exp_pc);
                end
                slot_full = 1'b1;
                slot_pc   = exp_pc;
                slot_err  = imem_error;
            end
        end
    end

    // ---------------------------------------------------------------------
    // Stimulus and end of run
    // ---------------------------------------------------------------------

    initial begin : stimulus
        int cycles;
        g_resetn     = 1'b0;
        cf_req       = 1'b0;
        cf_target    = PC_RESET_VALUE;
        imem_stall   = 1'b0;
        imem_error   = 1'b0;
        imem_rdata   = '0;
        s2_busy      = 1'b0;
        slot_full    = 1'b0;
        exp_pc       = PC_RESET_VALUE;
        hold_pending = 1'b0;
        cycles       = 0;
        repeat (3) @(negedge g_clk);
        g_resetn = 1'b1;
        while (transfers < 300 && cycles < 4000) begin
            drive_inputs();
            @(negedge g_clk);
            cycles++;
        end
        if (transfers < 300) begin
            errors++;
            $display("Timeout: only %0d items reached dispatch in %0d cycles", transfers, cycles);
        end
        if (n_illegal == 0 || n_fetch_err == 0 || redirects == 0) begin
            errors++;
            $display("Run never produced an illegal word, a fetch error and a redirect");
        end
        $display("Errors: %0d, items: %0d, redirects: %0d", errors, transfers, redirects);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule : frv_front_tb

// ==== build.f ====
+incdir+sim
logic/frv_core_pkg.sv
logic/frv_decode_pkg.sv
logic/frv_pipeline_fetch.sv
logic/frv_pipeline_decode.sv
logic/frv_pipeline_register.sv
logic/frv_pipeline_front.sv
sim/frv_front_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module frv_front_tb -o frv_front_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/frv_front_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
